/* hdl/sip_pkg.sv */
// shared widths for the serial inner-product slice
// opcode and lane state enums
package sip_pkg;

    // synapse and neuron widths
    localparam int SYN_W  = 16;
    localparam int NEUR_W = 16;

    // neurons per lane, also the adder tree fan-in
    localparam int TI = 16;

    // one extra bit so negating -32768 stays in range
    localparam int TERM_W = SYN_W + 1;

    // four adder levels, one bit of growth each
    localparam int TREE_W = TERM_W + 4;

    // accumulator, partial sum and result
    localparam int ACC_W = 40;

    // precision field, values 1 to 16
    localparam int PREC_W = 5;

    // synapse memory geometry
    localparam int SYN_AW   = 4;
    localparam int SYNVEC_W = TI * SYN_W;

    typedef enum logic [0:0] {
        OP_SUM,
        OP_MAX
    } sip_op_t;

    typedef enum logic [2:0] {
        L_IDLE,
        L_REQ,
        L_LOAD,
        L_RUN,
        L_DRAIN,
        L_DONE
    } lane_state_t;

endpackage

/* hdl/sip_adder_tree.sv */
// signed adder tree, TI terms down to one sum
// one register stage after the second level
module sip_adder_tree (
    input  logic                                      clk,
    input  logic [sip_pkg::TI*sip_pkg::TERM_W-1:0]    i_terms,
    output logic signed [sip_pkg::TREE_W-1:0]         o_sum
);
    import sip_pkg::*;

    // each level grows by one bit
    logic signed [TERM_W:0]   lvl0   [TI/2];
    logic signed [TERM_W+1:0] lvl1   [TI/4];
    logic signed [TERM_W+1:0] lvl1_q [TI/4];
    logic signed [TERM_W+2:0] lvl2   [TI/8];

    // first two levels, before the pipe register
    always_comb begin
        for (int i = 0; i < TI/2; i++) begin
            lvl0[i] = signed'(i_terms[(2*i)*TERM_W +: TERM_W])
                    + signed'(i_terms[(2*i+1)*TERM_W +: TERM_W]);
        end
        for (int i = 0; i < TI/4; i++) begin
            lvl1[i] = lvl0[2*i] + lvl0[2*i+1];
        end
    end

    // pipe register, no reset on data
    always_ff @(posedge clk) begin
        for (int i = 0; i < TI/4; i++) begin
            lvl1_q[i] <= lvl1[i];
        end
    end

    // last two levels after the register
    always_comb begin
        for (int i = 0; i < TI/8; i++) begin
            lvl2[i] = lvl1_q[2*i] + lvl1_q[2*i+1];
        end
        o_sum = lvl2[0] + lvl2[1];
    end

endmodule

/* hdl/sip_lane.sv */
// one bit-serial inner-product lane
// command capture, synapse fetch, serial multiply, accumulate, sum or max
module sip_lane (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      i_cmd_valid,
    input  sip_pkg::sip_op_t                          i_cmd_op,
    input  logic [sip_pkg::SYN_AW-1:0]                i_cmd_addr,
    input  logic [sip_pkg::PREC_W-1:0]                i_cmd_prec,
    input  logic signed [sip_pkg::ACC_W-1:0]          i_cmd_partial,
    input  logic [sip_pkg::TI*sip_pkg::NEUR_W-1:0]    i_cmd_neurons,
    output logic                                      o_syn_req,
    output logic [sip_pkg::SYN_AW-1:0]                o_syn_addr,
    input  logic                                      i_syn_gnt,
    input  logic [sip_pkg::SYNVEC_W-1:0]              i_syn_data,
    output logic                                      o_res_req,
    output logic signed [sip_pkg::ACC_W-1:0]          o_res_data,
    input  logic                                      i_res_ack,
    output logic                                      o_cmd_credit
);
    import sip_pkg::*;

    lane_state_t state;

    // captured command
    sip_op_t                  op_q;
    logic [SYN_AW-1:0]        addr_q;
    logic [PREC_W-1:0]        prec_q;
    logic signed [ACC_W-1:0]  partial_q;

    // neuron shift registers, current bit sits in the MSB
    logic [NEUR_W-1:0]        neur_sr [TI];
    logic [SYNVEC_W-1:0]      syn_q;
    logic [PREC_W-1:0]        bit_cnt;

    logic                     first_run;
    logic [TI*TERM_W-1:0]     terms;
    logic signed [TREE_W-1:0] tree_sum;
    logic signed [ACC_W-1:0]  tree_ext;
    logic                     tree_vld;
    logic                     tree_first;
    logic signed [ACC_W-1:0]  acc;

    // lane FSM and bit counter
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= L_IDLE;
            bit_cnt      <= '0;
            o_cmd_credit <= 1'b0;
        end else begin
            o_cmd_credit <= 1'b0;
            case (state)
                L_IDLE: if (i_cmd_valid) state <= L_REQ;
                L_REQ:  if (i_syn_gnt) state <= L_LOAD;
                L_LOAD: begin
                    state   <= L_RUN;
                    bit_cnt <= prec_q;
                end
                L_RUN: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    // last bit in flight, tree still holds it
                    if (bit_cnt == PREC_W'(1)) state <= L_DRAIN;
                end
                L_DRAIN: state <= L_DONE;
                L_DONE: begin
                    if (i_res_ack) begin
                        state        <= L_IDLE;
                        o_cmd_credit <= 1'b1;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    // command capture and neuron shifting
    always_ff @(posedge clk) begin
        if (state == L_IDLE && i_cmd_valid) begin
            op_q      <= i_cmd_op;
            addr_q    <= i_cmd_addr;
            prec_q    <= i_cmd_prec;
            partial_q <= i_cmd_partial;
            // align bit P-1 to the MSB
            for (int i = 0; i < TI; i++) begin
                neur_sr[i] <= i_cmd_neurons[i*NEUR_W +: NEUR_W] << (NEUR_W - i_cmd_prec);
            end
        end else if (state == L_RUN) begin
            for (int i = 0; i < TI; i++) begin
                neur_sr[i] <= neur_sr[i] << 1;
            end
        end
    end

    // synapse vector arrives the cycle after the grant
    always_ff @(posedge clk) begin
        if (state == L_LOAD) syn_q <= i_syn_data;
    end

    // MSB cycle carries negative weight
    assign first_run = (state == L_RUN) && (bit_cnt == prec_q);

    // one-bit products
    always_comb begin
        logic signed [TERM_W-1:0] syn_ext;
        for (int i = 0; i < TI; i++) begin
            syn_ext = signed'({syn_q[i*SYN_W + SYN_W-1], syn_q[i*SYN_W +: SYN_W]});
            if (!neur_sr[i][NEUR_W-1]) begin
                terms[i*TERM_W +: TERM_W] = '0;
            end else if (first_run) begin
                terms[i*TERM_W +: TERM_W] = -syn_ext;
            end else begin
                terms[i*TERM_W +: TERM_W] = syn_ext;
            end
        end
    end

    sip_adder_tree u_tree (
        .clk     (clk),
        .i_terms (terms),
        .o_sum   (tree_sum)
    );

    // tree output lags the terms by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            tree_vld   <= 1'b0;
            tree_first <= 1'b0;
        end else begin
            tree_vld   <= (state == L_RUN);
            tree_first <= first_run;
        end
    end

    assign tree_ext = {{(ACC_W-TREE_W){tree_sum[TREE_W-1]}}, tree_sum};

    // shift-and-add accumulator
    always_ff @(posedge clk) begin
        if (tree_vld) begin
            if (tree_first) acc <= tree_ext;
            else            acc <= (acc <<< 1) + tree_ext;
        end
    end

    assign o_syn_req  = (state == L_REQ);
    assign o_syn_addr = addr_q;
    assign o_res_req  = (state == L_DONE);

    // final op, signed compare for max pooling
    always_comb begin
        if (op_q == OP_MAX) o_res_data = (acc > partial_q) ? acc : partial_q;
        else                o_res_data = partial_q + acc;
    end

endmodule

/* hdl/rr_arbiter.sv */
// round-robin arbiter with rotating priority pointer
module rr_arbiter #(
    parameter int NUM_REQ = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [NUM_REQ-1:0] i_req,
    input  logic               i_enable,
    output logic [NUM_REQ-1:0] o_gnt
);

    localparam int PTR_W = $clog2(NUM_REQ);

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] win;

    // first requester at or after the pointer
    always_comb begin
        int  idx;
        logic found;
        o_gnt = '0;
        win   = '0;
        found = 1'b0;
        for (int off = 0; off < NUM_REQ; off++) begin
            idx = (int'(ptr) + off) % NUM_REQ;
            if (!found && i_enable && i_req[idx]) begin
                o_gnt[idx] = 1'b1;
                win        = PTR_W'(idx);
                found      = 1'b1;
            end
        end
    end

    // move past the winner
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (|o_gnt) begin
            ptr <= (int'(win) == NUM_REQ-1) ? '0 : win + 1'b1;
        end
    end

endmodule

/* hdl/synapse_mem.sv */
// synapse vector RAM
// external write port, one registered read port
module synapse_mem (
    input  logic                          clk,
    input  logic                          i_wr_en,
    input  logic [sip_pkg::SYN_AW-1:0]    i_wr_addr,
    input  logic [sip_pkg::SYNVEC_W-1:0]  i_wr_data,
    input  logic                          i_rd_en,
    input  logic [sip_pkg::SYN_AW-1:0]    i_rd_addr,
    output logic [sip_pkg::SYNVEC_W-1:0]  o_rd_data
);
    import sip_pkg::*;

    // one word per synapse vector
    logic [SYNVEC_W-1:0] mem [2**SYN_AW];

    always_ff @(posedge clk) begin
        if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
    end

    // same-cycle write leaves the old word on the read
    always_ff @(posedge clk) begin
        if (i_rd_en) o_rd_data <= mem[i_rd_addr];
    end

endmodule

/* hdl/result_credit_out.sv */
// result output stage with credit counter
// grants one finished lane per cycle while credits remain
module result_credit_out #(
    parameter int NUM_LANES   = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [NUM_LANES-1:0]                  i_res_req,
    input  logic [NUM_LANES*sip_pkg::ACC_W-1:0]   i_res_data,
    input  logic                                  i_res_credit,
    output logic [NUM_LANES-1:0]                  o_res_ack,
    output logic                                  o_res_valid,
    output logic [$clog2(NUM_LANES)-1:0]          o_res_lane,
    output logic signed [sip_pkg::ACC_W-1:0]      o_res_data
);
    import sip_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);
    localparam int CRED_W = $clog2(RES_CREDITS + 1);

    logic [CRED_W-1:0]    credits;
    logic [NUM_LANES-1:0] gnt;
    logic                 spend;
    logic [LANE_W-1:0]    gnt_lane;
    logic [ACC_W-1:0]     gnt_data;

    // no credits, no grant
    rr_arbiter #(
        .NUM_REQ (NUM_LANES)
    ) u_arb (
        .clk      (clk),
        .reset    (reset),
        .i_req    (i_res_req),
        .i_enable (credits != '0),
        .o_gnt    (gnt)
    );

    assign o_res_ack = gnt;
    assign spend     = |gnt;

    // one-hot to lane number and data
    always_comb begin
        gnt_lane = '0;
        gnt_data = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (gnt[l]) begin
                gnt_lane = LANE_W'(l);
                gnt_data = i_res_data[l*ACC_W +: ACC_W];
            end
        end
    end

    // spend and return may coincide
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CRED_W'(RES_CREDITS);
        end else begin
            case ({spend, i_res_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: if (credits < CRED_W'(RES_CREDITS)) credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) o_res_valid <= 1'b0;
        else       o_res_valid <= spend;
    end

    // payload only moves on a grant
    always_ff @(posedge clk) begin
        if (spend) begin
            o_res_lane <= gnt_lane;
            o_res_data <= gnt_data;
        end
    end

endmodule

/* hdl/sip_slice_top.sv */
// serial inner-product slice top level
// lanes, synapse arbiter and memory, result output stage
module sip_slice_top #(
    parameter int NUM_LANES   = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      i_cmd_valid,
    input  logic [$clog2(NUM_LANES)-1:0]              i_cmd_lane,
    input  sip_pkg::sip_op_t                          i_cmd_op,
    input  logic [sip_pkg::SYN_AW-1:0]                i_cmd_addr,
    input  logic [sip_pkg::PREC_W-1:0]                i_cmd_prec,
    input  logic signed [sip_pkg::ACC_W-1:0]          i_cmd_partial,
    input  logic [sip_pkg::TI*sip_pkg::NEUR_W-1:0]    i_cmd_neurons,
    output logic [NUM_LANES-1:0]                      o_cmd_credit,
    input  logic                                      i_syn_wr_en,
    input  logic [sip_pkg::SYN_AW-1:0]                i_syn_wr_addr,
    input  logic [sip_pkg::SYNVEC_W-1:0]              i_syn_wr_data,
    output logic                                      o_res_valid,
    output logic [$clog2(NUM_LANES)-1:0]              o_res_lane,
    output logic signed [sip_pkg::ACC_W-1:0]          o_res_data,
    input  logic                                      i_res_credit
);
    import sip_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);

    logic [NUM_LANES-1:0]       lane_cmd_valid;
    logic [NUM_LANES-1:0]       syn_req;
    logic [NUM_LANES-1:0]       syn_gnt;
    logic [NUM_LANES-1:0]       syn_gnt_q;
    logic [SYN_AW-1:0]          lane_syn_addr [NUM_LANES];
    logic [SYNVEC_W-1:0]        lane_syn_data [NUM_LANES];
    logic [SYN_AW-1:0]          rd_addr;
    logic [SYNVEC_W-1:0]        rd_data;
    logic [NUM_LANES-1:0]       res_req;
    logic [NUM_LANES-1:0]       res_ack;
    logic [NUM_LANES*ACC_W-1:0] lane_res_data;

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        // lane select decode
        assign lane_cmd_valid[l] = i_cmd_valid && (i_cmd_lane == LANE_W'(l));
        // read data only reaches the lane granted last cycle
        assign lane_syn_data[l]  = syn_gnt_q[l] ? rd_data : '0;

        sip_lane u_lane (
            .clk           (clk),
            .reset         (reset),
            .i_cmd_valid   (lane_cmd_valid[l]),
            .i_cmd_op      (i_cmd_op),
            .i_cmd_addr    (i_cmd_addr),
            .i_cmd_prec    (i_cmd_prec),
            .i_cmd_partial (i_cmd_partial),
            .i_cmd_neurons (i_cmd_neurons),
            .o_syn_req     (syn_req[l]),
            .o_syn_addr    (lane_syn_addr[l]),
            .i_syn_gnt     (syn_gnt[l]),
            .i_syn_data    (lane_syn_data[l]),
            .o_res_req     (res_req[l]),
            .o_res_data    (lane_res_data[l*ACC_W +: ACC_W]),
            .i_res_ack     (res_ack[l]),
            .o_cmd_credit  (o_cmd_credit[l])
        );
    end

    // synapse read port, always open
    rr_arbiter #(
        .NUM_REQ (NUM_LANES)
    ) u_syn_arb (
        .clk      (clk),
        .reset    (reset),
        .i_req    (syn_req),
        .i_enable (1'b1),
        .o_gnt    (syn_gnt)
    );

    // granted lane drives the read address
    always_comb begin
        rd_addr = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (syn_gnt[l]) rd_addr = lane_syn_addr[l];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) syn_gnt_q <= '0;
        else       syn_gnt_q <= syn_gnt;
    end

    synapse_mem u_syn_mem (
        .clk       (clk),
        .i_wr_en   (i_syn_wr_en),
        .i_wr_addr (i_syn_wr_addr),
        .i_wr_data (i_syn_wr_data),
        .i_rd_en   (|syn_gnt),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    result_credit_out #(
        .NUM_LANES   (NUM_LANES),
        .RES_CREDITS (RES_CREDITS)
    ) u_res_out (
        .clk          (clk),
        .reset        (reset),
        .i_res_req    (res_req),
        .i_res_data   (lane_res_data),
        .i_res_credit (i_res_credit),
        .o_res_ack    (res_ack),
        .o_res_valid  (o_res_valid),
        .o_res_lane   (o_res_lane),
        .o_res_data   (o_res_data)
    );

endmodule

/* bench/sip_slice_tb.sv */
// testbench for the serial inner-product slice
// directed tests checked against a longint reference model
module sip_slice_tb;
    import sip_pkg::*;

    localparam int NUM_LANES   = 4;
    localparam int RES_CREDITS = 2;
    localparam int LANE_W      = $clog2(NUM_LANES);
    // commands over all six tests
    localparam int NUM_CMDS    = 57;
    localparam int CYCLE_LIMIT = NUM_CMDS * (16 + 5 + NUM_LANES) + 2000;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    i_cmd_valid;
    logic [LANE_W-1:0]       i_cmd_lane;
    sip_op_t                 i_cmd_op;
    logic [SYN_AW-1:0]       i_cmd_addr;
    logic [PREC_W-1:0]       i_cmd_prec;
    logic signed [ACC_W-1:0] i_cmd_partial;
    logic [TI*NEUR_W-1:0]    i_cmd_neurons;
    logic [NUM_LANES-1:0]    o_cmd_credit;
    logic                    i_syn_wr_en;
    logic [SYN_AW-1:0]       i_syn_wr_addr;
    logic [SYNVEC_W-1:0]     i_syn_wr_data;
    logic                    o_res_valid;
    logic [LANE_W-1:0]       o_res_lane;
    logic signed [ACC_W-1:0] o_res_data;
    logic                    i_res_credit = 1'b0;

    // memory image as the testbench wrote it
    logic [SYNVEC_W-1:0] syn_model [2**SYN_AW];

    // command credits are 1 - issued + returned per lane
    int issued   [NUM_LANES] = '{default: 0};
    int returned [NUM_LANES] = '{default: 0};
    // output credits are RES_CREDITS - res_seen + cred_sent
    int res_seen  = 0;
    int cred_sent = 0;
    bit auto_credit = 1'b1;

    int unsigned cycle_cnt = 0;
    int errors     = 0;
    int checks     = 0;
    int mon_errors = 0;
    int mon_checks = 0;

    // outstanding commands, oldest first
    int     exp_lane_q  [$];
    longint exp_val_q   [$];
    int     exp_cycle_q [$];
    int     exp_lat_q   [$];

    // results in arrival order
    int     res_lane_q  [$];
    longint res_val_q   [$];
    int     res_cycle_q [$];

    sip_slice_top #(
        .NUM_LANES   (NUM_LANES),
        .RES_CREDITS (RES_CREDITS)
    ) dut (
        .clk           (clk),
        .reset         (reset),
        .i_cmd_valid   (i_cmd_valid),
        .i_cmd_lane    (i_cmd_lane),
        .i_cmd_op      (i_cmd_op),
        .i_cmd_addr    (i_cmd_addr),
        .i_cmd_prec    (i_cmd_prec),
        .i_cmd_partial (i_cmd_partial),
        .i_cmd_neurons (i_cmd_neurons),
        .o_cmd_credit  (o_cmd_credit),
        .i_syn_wr_en   (i_syn_wr_en),
        .i_syn_wr_addr (i_syn_wr_addr),
        .i_syn_wr_data (i_syn_wr_data),
        .o_res_valid   (o_res_valid),
        .o_res_lane    (o_res_lane),
        .o_res_data    (o_res_data),
        .i_res_credit  (i_res_credit)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (o_cmd_credit[l]) begin
                    returned[l]++;
                end
            end
            if (o_res_valid) begin
                mon_checks++;
                assert (RES_CREDITS - res_seen + cred_sent > 0) else begin
                    $display("[ERROR] %0t result left the DUT with no output credit held", $time);
                    mon_errors++;
                end
                res_seen++;
                res_lane_q.push_back(int'(o_res_lane));
                res_val_q.push_back(longint'(o_res_data));
                res_cycle_q.push_back(int'(cycle_cnt));
            end
        end
    end

    // consumer side, one credit back per result
    always @(posedge clk) begin
        #1;
        if (auto_credit && res_seen > cred_sent) begin
            i_res_credit = 1'b1;
            cred_sent++;
        end else begin
            i_res_credit = 1'b0;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [SYNVEC_W-1:0] rand_vec();
        logic [SYNVEC_W-1:0] v;
        for (int i = 0; i < TI; i++) begin
            v[i*16 +: 16] = 16'($urandom);
        end
        return v;
    endfunction

    function automatic longint rand_partial();
        return longint'(int'($urandom));
    endfunction

    // P-bit two's complement neurons times signed synapses
    function automatic longint model_dot(input logic [SYNVEC_W-1:0] syn,
                                         input logic [TI*NEUR_W-1:0] neur, input int prec);
        longint sum;
        longint n;
        longint s;
        sum = 0;
        for (int i = 0; i < TI; i++) begin
            n = longint'(neur[i*NEUR_W +: NEUR_W]) & ((64'sd1 <<< prec) - 1);
            // top bit of P carries negative weight
            if (n >= (64'sd1 <<< (prec - 1))) begin
                n = n - (64'sd1 <<< prec);
            end
            s = longint'(signed'(syn[i*SYN_W +: SYN_W]));
            sum = sum + n * s;
        end
        return sum;
    endfunction

    task automatic write_syn(input int addr, input logic [SYNVEC_W-1:0] vec);
        i_syn_wr_en     = 1'b1;
        i_syn_wr_addr   = SYN_AW'(addr);
        i_syn_wr_data   = vec;
        syn_model[addr] = vec;
        next_cycle();
        i_syn_wr_en = 1'b0;
    endtask

    task automatic fill_mem();
        for (int a = 0; a < 2**SYN_AW; a++) begin
            write_syn(a, rand_vec());
        end
    endtask

    // waits for a lane credit, then one valid cycle
    task automatic issue(input int lane, input sip_op_t op, input int addr, input int prec,
                         input longint partial, input logic [TI*NEUR_W-1:0] neur);
        longint dot;
        longint want;
        while (1 - issued[lane] + returned[lane] == 0) begin
            next_cycle();
        end
        dot = model_dot(syn_model[addr], neur, prec);
        if (op == OP_MAX) begin
            want = (partial > dot) ? partial : dot;
        end else begin
            want = partial + dot;
        end
        i_cmd_valid   = 1'b1;
        i_cmd_lane    = LANE_W'(lane);
        i_cmd_op      = op;
        i_cmd_addr    = SYN_AW'(addr);
        i_cmd_prec    = PREC_W'(prec);
        i_cmd_partial = ACC_W'(partial);
        i_cmd_neurons = neur;
        issued[lane]++;
        exp_lane_q.push_back(lane);
        exp_val_q.push_back(want);
        exp_cycle_q.push_back(int'(cycle_cnt));
        exp_lat_q.push_back(prec + 5);
        next_cycle();
        i_cmd_valid = 1'b0;
    endtask

    task automatic wait_results(input int n);
        while (res_lane_q.size() < n) begin
            next_cycle();
        end
    endtask

    // match each result to the oldest command of its lane
    task automatic collect(input int n, input bit check_lat);
        int     lane;
        longint got;
        int     cyc;
        int     idx;
        wait_results(n);
        for (int k = 0; k < n; k++) begin
            lane = res_lane_q.pop_front();
            got  = res_val_q.pop_front();
            cyc  = res_cycle_q.pop_front();
            idx  = -1;
            for (int j = exp_lane_q.size() - 1; j >= 0; j--) begin
                if (exp_lane_q[j] == lane) begin
                    idx = j;
                end
            end
            checks++;
            assert (idx >= 0) else begin
                $display("[ERROR] %0t result from lane %0d with no command outstanding",
                         $time, lane);
                errors++;
            end
            if (idx >= 0) begin
                assert (got == exp_val_q[idx]) else begin
                    $display("[ERROR] %0t o_res_data lane %0d expected %0d got %0d",
                             $time, lane, exp_val_q[idx], got);
                    errors++;
                end
                if (check_lat) begin
                    assert (cyc - exp_cycle_q[idx] == exp_lat_q[idx]) else begin
                        $display("[ERROR] %0t o_res_valid latency expected %0d got %0d",
                                 $time, exp_lat_q[idx], cyc - exp_cycle_q[idx]);
                        errors++;
                    end
                end
                exp_lane_q.delete(idx);
                exp_val_q.delete(idx);
                exp_cycle_q.delete(idx);
                exp_lat_q.delete(idx);
            end
        end
    endtask

    task automatic report(input string name, input int err0);
        $display("[test] %s finished, %0d errors", name, errors + mon_errors - err0);
    endtask

    task automatic single_sum_test();
        int err0;
        err0 = errors + mon_errors;
        issue(2, OP_SUM, 5, 16, rand_partial(), rand_vec());
        wait_results(1);
        checks++;
        assert (res_lane_q[0] == 2) else begin
            $display("[ERROR] %0t o_res_lane expected 2 got %0d", $time, res_lane_q[0]);
            errors++;
        end
        // no contention, so fixed latency
        collect(1, 1'b1);
        report("single lane sum", err0);
    endtask

    task automatic precision_sweep_test();
        int err0;
        int precs [4];
        logic [SYNVEC_W-1:0] vec;
        logic [TI*NEUR_W-1:0] neur;
        err0  = errors + mon_errors;
        precs = '{1, 4, 8, 16};
        // most negative synapse in element 0
        vec = rand_vec();
        vec[15:0] = 16'h8000;
        write_syn(9, vec);
        for (int k = 0; k < 4; k++) begin
            neur = rand_vec();
            neur[15:0] = 16'(1 << (precs[k] - 1));
            issue(k, OP_SUM, 9, precs[k], rand_partial(), neur);
        end
        collect(4, 1'b0);
        report("precision sweep", err0);
    endtask

    task automatic max_pool_test();
        int err0;
        longint dot;
        logic [SYNVEC_W-1:0] pos;
        logic [TI*NEUR_W-1:0] neur;
        logic [TI*NEUR_W-1:0] neg;
        err0 = errors + mon_errors;
        // positive synapses with negative 8-bit neurons give a negative dot
        for (int i = 0; i < TI; i++) begin
            pos[i*SYN_W +: SYN_W] = 16'($urandom_range(1, 2000));
            neg[i*NEUR_W +: NEUR_W] = {8'h00, 1'b1, 7'($urandom)};
        end
        write_syn(15, pos);
        neur = rand_vec();
        dot  = model_dot(syn_model[3], neur, 16);
        issue(0, OP_MAX, 3, 16, dot + 12345, neur);
        neur = rand_vec();
        dot  = model_dot(syn_model[3], neur, 16);
        issue(1, OP_MAX, 3, 16, dot - 777, neur);
        dot  = model_dot(syn_model[15], neg, 8);
        issue(2, OP_MAX, 15, 8, dot - 5, neg);
        issue(3, OP_MAX, 15, 8, dot + 3, neg);
        collect(4, 1'b0);
        report("max pooling", err0);
    endtask

    task automatic all_lanes_test();
        int err0;
        int addrs [4];
        int precs [4];
        err0  = errors + mon_errors;
        addrs = '{1, 3, 7, 11};
        precs = '{16, 12, 7, 3};
        // one command per cycle, so back to back
        for (int l = 0; l < NUM_LANES; l++) begin
            issue(l, (l % 2 == 1) ? OP_MAX : OP_SUM, addrs[l], precs[l],
                  rand_partial(), rand_vec());
        end
        collect(4, 1'b0);
        repeat (30) next_cycle();
        checks++;
        assert (res_lane_q.size() == 0 && exp_lane_q.size() == 0) else begin
            $display("results duplicated or lost, %0d extra results, %0d commands open",
                     res_lane_q.size(), exp_lane_q.size());
            errors++;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            checks++;
            assert (returned[l] == issued[l]) else begin
                $display("[ERROR] %0t o_cmd_credit lane %0d expected %0d got %0d",
                         $time, l, issued[l], returned[l]);
                errors++;
            end
        end
        report("all lanes", err0);
    endtask

    task automatic back_pressure_test();
        int err0;
        err0 = errors + mon_errors;
        auto_credit = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            issue(l, OP_SUM, 2 * l, 6, rand_partial(), rand_vec());
        end
        repeat (60) next_cycle();
        checks++;
        assert (res_lane_q.size() <= RES_CREDITS) else begin
            $display("[ERROR] %0t result count expected at most %0d got %0d",
                     $time, RES_CREDITS, res_lane_q.size());
            errors++;
        end
        auto_credit = 1'b1;
        collect(4, 1'b0);
        report("back pressure", err0);
    endtask

    task automatic random_stream_test();
        int err0;
        int lane;
        int prec;
        int addr;
        sip_op_t op;
        err0 = errors + mon_errors;
        // five batches of eight, memory rewritten while all lanes idle
        for (int b = 0; b < 5; b++) begin
            fill_mem();
            for (int k = 0; k < 8; k++) begin
                lane = int'($urandom_range(0, NUM_LANES - 1));
                prec = int'($urandom_range(1, 16));
                addr = int'($urandom_range(0, 2**SYN_AW - 1));
                op   = sip_op_t'($urandom_range(0, 1));
                issue(lane, op, addr, prec, rand_partial(), rand_vec());
            end
            collect(8, 1'b0);
        end
        report("random stream", err0);
    endtask

    initial begin
        int seed_val;
        int total;
        seed_val      = $urandom(32'h62ed_99f0);
        reset         = 1'b1;
        i_cmd_valid   = 1'b0;
        i_cmd_lane    = '0;
        i_cmd_op      = OP_SUM;
        i_cmd_addr    = '0;
        i_cmd_prec    = '0;
        i_cmd_partial = '0;
        i_cmd_neurons = '0;
        i_syn_wr_en   = 1'b0;
        i_syn_wr_addr = '0;
        i_syn_wr_data = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        fill_mem();
        single_sum_test();
        precision_sweep_test();
        max_pool_test();
        all_lanes_test();
        back_pressure_test();
        random_stream_test();
        total = errors + mon_errors;
        $display("checks %0d, errors %0d", checks + mon_checks, total);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog on the cycle counter
    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout after %0d cycles, the tests did not finish", CYCLE_LIMIT);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* sip_slice.f */
hdl/sip_pkg.sv
hdl/sip_adder_tree.sv
hdl/sip_lane.sv
hdl/rr_arbiter.sv
hdl/synapse_mem.sv
hdl/result_credit_out.sv
hdl/sip_slice_top.sv
bench/sip_slice_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
TOP       = sip_slice_tb
FILELIST  = sip_slice.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
